//--- Makefile
# Verilator build and run of the register file testbench
# override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP ?= tbRegFile6R3W
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

# a failing run stops on $fatal, so the exit status carries the result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
+incdir+.
gprPkg.sv
gprBankFile.sv
specialRegs.sv
readPort.sv
regFile6R3W.sv
tbRegFile6R3W.sv

//--- gprBankFile.sv
// general registers in three lane banks behind a live-value table; bank contents have no reset
`timescale 1ns/1ns

module gprBankFile #(
	parameter int numRegs = 32
) (
	input logic clock,
	input logic rstN,
	input logic writeEn,
	input gprPkg::laneWrites_t writeBack,
	input gprPkg::gprIdx_t [gprPkg::numReadPorts-1:0] rdIdx,
	output gprPkg::regVal_t [gprPkg::numReadPorts-1:0] rdVal
);
	import gprPkg::*;

	regVal_t bank [numLanes][numRegs]; // one copy per writing lane
	logic [1:0] lvt [numRegs]; // which lane wrote each register last

	logic [numLanes-1:0] laneWe;
	gprIdx_t wrIdx [numLanes];

	// ids at or above numRegs are specials or immediates, no bank write
	always_comb
	begin
		for (int l = 0; l < numLanes; l++)
		begin
			laneWe[l] = writeEn && (writeBack[l].id < regId_t'(numRegs));
			wrIdx[l] = gprIdx_t'(writeBack[l].id); // low bits only
		end
	end

	// each lane owns its bank, so no write port conflicts
	always_ff @(posedge clock)
	begin
		for (int l = 0; l < numLanes; l++)
		begin
			if (laneWe[l])
				bank[l][wrIdx[l]] <= writeBack[l].val;
		end
	end

	// live-value table
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			for (int r = 0; r < numRegs; r++)
				lvt[r] <= 2'd0; // everything points at bank A
		end
		else
		begin
			// loop order gives C over B over A on a collision
			for (int l = 0; l < numLanes; l++)
			begin
				if (laneWe[l])
					lvt[wrIdx[l]] <= 2'(l);
			end
		end
	end

	// raw reads, no forwarding here
	always_comb
	begin
		for (int p = 0; p < numReadPorts; p++)
			rdVal[p] = bank[lvt[rdIdx[p]]][rdIdx[p]];
	end

endmodule

//--- gprPkg.sv
// shared types for the 6R3W register file; ids 0-31 are general, 32 and up special codes
package gprPkg;

	localparam int numLanes = 3; // issue lanes A, B, C
	localparam int numStages = 3; // EX1..EX3 forwarding
	localparam int numReadPorts = 6; // S T U V X Y

	localparam int idWidth = 6;
	localparam int gprIdxWidth = 5; // index into one lane bank
	localparam int valWidth = 64;
	localparam int immWidth = 33; // top bit is the sign

	typedef logic [idWidth-1:0] regId_t;
	typedef logic [gprIdxWidth-1:0] gprIdx_t;
	typedef logic [valWidth-1:0] regVal_t;
	typedef logic [immWidth-1:0] imm_t;

	// special codes above the general range
	localparam regId_t idDlr = 6'd32;
	localparam regId_t idDhr = 6'd33;
	localparam regId_t idSp = 6'd34;
	localparam regId_t idImm = 6'd62; // lane immediate, never forwarded
	localparam regId_t idZzr = 6'd63; // zero register

	// one lane's write-back
	typedef struct packed
	{
		regId_t id;
		regVal_t val;
	} regWrite_t;

	// one stage-lane result on the forwarding network
	typedef struct packed
	{
		logic held; // value not ready yet
		regWrite_t wr;
	} fwdEntry_t;

	// index 0 is lane A
	typedef regWrite_t [numLanes-1:0] laneWrites_t;

	// [stage][lane], stage 0 is EX1 and lane 0 is A
	typedef fwdEntry_t [numStages-1:0][numLanes-1:0] fwdStages_t;

endpackage

//--- readPort.sv
// one operand read port; forwarding also applies to unallowed or undefined ids, never to IMM/ZZR
`timescale 1ns/1ns

module readPort #(
	parameter bit allowDhr = 1'b1,
	parameter bit allowSp = 1'b1
) (
	input gprPkg::regId_t src,
	input gprPkg::imm_t imm,
	input gprPkg::regVal_t gprVal,
	input gprPkg::regVal_t dlr,
	input gprPkg::regVal_t dhr,
	input gprPkg::regVal_t sp,
	input gprPkg::fwdStages_t fwd,
	output gprPkg::regVal_t val
);
	import gprPkg::*;

	regVal_t baseVal; // value before forwarding
	regVal_t immExt;
	logic noFwd; // IMM and ZZR bypass the forward network

	logic fwdHit;
	regVal_t fwdVal;

	assign immExt = {{(valWidth-immWidth){imm[immWidth-1]}}, imm};

	// base value by id class
	always_comb
	begin
		noFwd = 1'b0;
		if (!src[idWidth-1]) // ids below 32
		begin
			baseVal = gprVal;
		end
		else
		begin
			case (src)
				idDlr:
					baseVal = dlr; // every port sees DLR
				idDhr:
					baseVal = allowDhr ? dhr : '0;
				idSp:
					baseVal = allowSp ? sp : '0;
				idImm:
				begin
					baseVal = immExt;
					noFwd = 1'b1;
				end
				idZzr:
				begin
					baseVal = '0;
					noFwd = 1'b1;
				end
				default:
					baseVal = '0; // unused code
			endcase
		end
	end

	// first non-held match wins
	// scan order EX1 A B C, then EX2, then EX3
	always_comb
	begin
		fwdHit = 1'b0;
		fwdVal = '0;
		for (int s = 0; s < numStages; s++)
		begin
			for (int l = 0; l < numLanes; l++)
			begin
				if (!fwdHit && !fwd[s][l].held && (fwd[s][l].wr.id == src))
				begin
					fwdHit = 1'b1;
					fwdVal = fwd[s][l].wr.val;
				end
			end
		end
	end

	assign val = (fwdHit && !noFwd) ? fwdVal : baseVal;

endmodule

//--- regFile6R3W.sv
// 6-read 3-write register file; reads are combinational, writes land one edge later
`timescale 1ns/1ns

module regFile6R3W #(
	parameter int numRegs = 32,
	parameter gprPkg::regVal_t resetVal = '0
) (
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic flush,
	input gprPkg::regId_t srcS,
	input gprPkg::regId_t srcT,
	input gprPkg::regId_t srcU,
	input gprPkg::regId_t srcV,
	input gprPkg::regId_t srcX,
	input gprPkg::regId_t srcY,
	input gprPkg::imm_t immA,
	input gprPkg::imm_t immB,
	input gprPkg::imm_t immC,
	input gprPkg::fwdStages_t fwd,
	input gprPkg::laneWrites_t writeBack,
	output gprPkg::regVal_t valS,
	output gprPkg::regVal_t valT,
	output gprPkg::regVal_t valU,
	output gprPkg::regVal_t valV,
	output gprPkg::regVal_t valX,
	output gprPkg::regVal_t valY,
	output gprPkg::regVal_t regOutDlr,
	output gprPkg::regVal_t regOutDhr,
	output gprPkg::regVal_t regOutSp
);
	import gprPkg::*;

	// per-port special access, bit order Y X V U T S
	localparam bit [numReadPorts-1:0] dhrMask = 6'b101111; // X gets DLR only
	localparam bit [numReadPorts-1:0] spMask = 6'b000111; // SP on S T U

	logic writeEn;
	regId_t [numReadPorts-1:0] srcs;
	imm_t [numReadPorts-1:0] imms;
	gprIdx_t [numReadPorts-1:0] rdIdx;
	regVal_t [numReadPorts-1:0] rawVal;
	regVal_t [numReadPorts-1:0] vals;

	assign writeEn = !hold && !flush; // write-back stage gate

	assign srcs = {srcY, srcX, srcV, srcU, srcT, srcS};
	assign imms = {immC, immC, immB, immB, immA, immA}; // lane of each port pair

	always_comb
	begin
		for (int p = 0; p < numReadPorts; p++)
			rdIdx[p] = gprIdx_t'(srcs[p]); // bank index, class checked in readPort
	end

	gprBankFile #(
		.numRegs(numRegs)
	) banks (
		.clock(clock),
		.rstN(rstN),
		.writeEn(writeEn),
		.writeBack(writeBack),
		.rdIdx(rdIdx),
		.rdVal(rawVal)
	);

	specialRegs #(
		.resetVal(resetVal)
	) specials (
		.clock(clock),
		.rstN(rstN),
		.writeEn(writeEn),
		.writeBack(writeBack),
		.dlr(regOutDlr),
		.dhr(regOutDhr),
		.sp(regOutSp)
	);

	for (genvar p = 0; p < numReadPorts; p++)
	begin : portGen
		readPort #(
			.allowDhr(dhrMask[p]),
			.allowSp(spMask[p])
		) port (
			.src(srcs[p]),
			.imm(imms[p]),
			.gprVal(rawVal[p]),
			.dlr(regOutDlr),
			.dhr(regOutDhr),
			.sp(regOutSp),
			.fwd(fwd),
			.val(vals[p])
		);
	end

	assign valS = vals[0];
	assign valT = vals[1];
	assign valU = vals[2];
	assign valV = vals[3];
	assign valX = vals[4];
	assign valY = vals[5];

endmodule

//--- specialRegs.sv
// DLR, DHR and SP; DHR and SP see lanes A and B only, lane C writes to them are dropped
`timescale 1ns/1ns

module specialRegs #(
	parameter gprPkg::regVal_t resetVal = '0
) (
	input logic clock,
	input logic rstN,
	input logic writeEn,
	input gprPkg::laneWrites_t writeBack,
	output gprPkg::regVal_t dlr,
	output gprPkg::regVal_t dhr,
	output gprPkg::regVal_t sp
);
	import gprPkg::*;

	localparam int narrowLanes = 2; // lanes A and B

	// later lane overrides earlier, unmatched keeps current value
	function automatic regVal_t nextSpecial(
		input regId_t code,
		input int unsigned lanes,
		input regVal_t cur,
		input laneWrites_t wb
	);
		regVal_t res;
		res = cur;
		for (int l = 0; l < numLanes; l++)
		begin
			if ((l < lanes) && (wb[l].id == code))
				res = wb[l].val;
		end
		return res;
	endfunction

	regVal_t dlrNext;
	regVal_t dhrNext;
	regVal_t spNext;

	always_comb
	begin
		dlrNext = nextSpecial(idDlr, numLanes, dlr, writeBack); // all three lanes
		dhrNext = nextSpecial(idDhr, narrowLanes, dhr, writeBack);
		spNext = nextSpecial(idSp, narrowLanes, sp, writeBack);
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			dlr <= resetVal;
			dhr <= resetVal;
			sp <= resetVal;
		end
		else if (writeEn) // hold or flush freezes all three
		begin
			dlr <= dlrNext;
			dhr <= dhrNext;
			sp <= spNext;
		end
	end

endmodule

//--- tbModel.svh
// testbench reference model, included after the gprPkg import; bank data has no reset value
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

regVal_t gprModel [32]; // architectural view of the general registers
regVal_t dlrModel;
regVal_t dhrModel;
regVal_t spModel;

// reset only touches the specials
task automatic modelReset();
	dlrModel = '0;
	dhrModel = '0;
	spModel = '0;
endtask

// one enabled edge; lanes applied A first so a later lane overwrites
task automatic modelWrite(input laneWrites_t wb);
	for (int l = 0; l < numLanes; l++)
	begin
		if (wb[l].id < 6'd32)
			gprModel[wb[l].id[4:0]] = wb[l].val;
		if (wb[l].id == idDlr)
			dlrModel = wb[l].val; // all lanes
		if ((l < 2) && (wb[l].id == idDhr))
			dhrModel = wb[l].val; // lanes A and B only
		if ((l < 2) && (wb[l].id == idSp))
			spModel = wb[l].val;
	end
endtask

// port order S T U V X Y
function automatic bit portSeesDhr(input int port);
	return (port != 4); // X reads DLR only
endfunction

function automatic bit portSeesSp(input int port);
	return (port < 3); // S T U
endfunction

// expected operand for one port
function automatic regVal_t expectOperand(input int port, input regId_t src, input imm_t imm,
	input fwdStages_t f);
	regVal_t res;
	bit hit;
	hit = 1'b0;
	res = '0;
	if (src == idImm)
		return {{31{imm[32]}}, imm}; // sign from bit 32
	if (src == idZzr)
		return '0;
	for (int s = 0; s < numStages; s++)
	begin
		for (int l = 0; l < numLanes; l++)
		begin
			if (!hit && !f[s][l].held && (f[s][l].wr.id == src))
			begin
				hit = 1'b1; // earliest stage, then earliest lane
				res = f[s][l].wr.val;
			end
		end
	end
	if (hit)
		return res;
	if (src < 6'd32)
		res = gprModel[src[4:0]];
	else if (src == idDlr)
		res = dlrModel;
	else if (src == idDhr)
		res = portSeesDhr(port) ? dhrModel : '0;
	else if (src == idSp)
		res = portSeesSp(port) ? spModel : '0;
	return res; // unused codes stay zero
endfunction

`endif

//--- tbRegFile6R3W.sv
// seeded random test of the 6R3W register file; general reads begin once all 32 are written
`timescale 1ns/1ns

module tbRegFile6R3W;
	import gprPkg::*;

	`include "tbModel.svh"

	localparam int resetCycles = 10;
	localparam int initCycles = 32; // one general register per cycle on lane A
	localparam int randomCycles = 2000;
	localparam int timeoutCycles = resetCycles + initCycles + randomCycles + 158; // 2200
	localparam int unsigned runSeed = 32'hff6a420c;

	logic clock;
	logic rstN;
	logic hold;
	logic flush;
	regId_t src [numReadPorts]; // S T U V X Y
	imm_t immA;
	imm_t immB;
	imm_t immC;
	fwdStages_t fwd;
	laneWrites_t writeBack;
	regVal_t val [numReadPorts];
	regVal_t regOutDlr;
	regVal_t regOutDhr;
	regVal_t regOutSp;

	int cycleCount = 0;
	string portName [numReadPorts] = '{"valS", "valT", "valU", "valV", "valX", "valY"};

	regFile6R3W #(
		.numRegs(32),
		.resetVal('0)
	) DUT (
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.flush(flush),
		.srcS(src[0]),
		.srcT(src[1]),
		.srcU(src[2]),
		.srcV(src[3]),
		.srcX(src[4]),
		.srcY(src[5]),
		.immA(immA),
		.immB(immB),
		.immC(immC),
		.fwd(fwd),
		.writeBack(writeBack),
		.valS(val[0]),
		.valT(val[1]),
		.valU(val[2]),
		.valV(val[3]),
		.valX(val[4]),
		.valY(val[5]),
		.regOutDlr(regOutDlr),
		.regOutDhr(regOutDhr),
		.regOutSp(regOutSp)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// hard stop in case the main loop stalls
	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Test FAILED");
			$fatal(1, "timeout after %0d cycles, stimulus loop never finished", cycleCount);
		end
	end

	task automatic checkOperand(input string name, input regVal_t actual, input regVal_t expected);
		if (actual !== expected)
		begin
			$display("FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, expected,
				actual);
			$display("Test FAILED");
			$fatal(1, "operand mismatch");
		end
	endtask

	task automatic checkSpecial(input string name, input regVal_t actual, input regVal_t expected);
		if (actual !== expected)
		begin
			$display("FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, expected,
				actual);
			$display("Test FAILED");
			$fatal(1, "special register mismatch");
		end
	endtask

	// no general ids while the banks are still unwritten
	function automatic regId_t pickSource(input bit onlySpecial);
		int unsigned r;
		r = onlySpecial ? $urandom_range(99, 45) : $urandom_range(99, 0);
		if (r < 45)
			return regId_t'($urandom_range(31, 0));
		else if (r < 60)
			return idDlr;
		else if (r < 70)
			return idDhr;
		else if (r < 80)
			return idSp;
		else if (r < 88)
			return idImm;
		else if (r < 94)
			return idZzr;
		return regId_t'($urandom_range(61, 35)); // unused codes
	endfunction

	function automatic regVal_t randVal();
		return {$urandom, $urandom};
	endfunction

	function automatic imm_t portImm(input int port);
		if (port < 2)
			return immA;
		else if (port < 4)
			return immB;
		return immC;
	endfunction

	// new inputs for one cycle, driven right after the rising edge
	task automatic driveCycle(input bit initPhase, input int idx);
		regId_t s [numReadPorts];
		fwdStages_t f;
		laneWrites_t wb;
		int unsigned k;
		for (int p = 0; p < numReadPorts; p++)
			s[p] = pickSource(initPhase);
		for (int st = 0; st < numStages; st++)
		begin
			for (int l = 0; l < numLanes; l++)
			begin
				k = $urandom_range(5, 0);
				f[st][l].held = ($urandom_range(3, 0) == 0);
				// bias to hits
				f[st][l].wr.id = ($urandom_range(1, 0) == 0) ? s[k] : pickSource(1'b0);
				f[st][l].wr.val = randVal();
			end
		end
		for (int l = 0; l < numLanes; l++)
		begin
			wb[l].id = pickSource(initPhase);
			wb[l].val = randVal();
		end
		if ($urandom_range(3, 0) == 0)
			wb[2].id = wb[0].id; // lane collision, C must win
		if ($urandom_range(5, 0) == 0)
			wb[1].id = wb[0].id;
		if (initPhase)
			wb[0].id = regId_t'(idx); // fill general registers in order
		for (int p = 0; p < numReadPorts; p++)
			src[p] <= s[p];
		fwd <= f;
		writeBack <= wb;
		immA <= imm_t'({1'($urandom_range(1, 0)), $urandom});
		immB <= imm_t'({1'($urandom_range(1, 0)), $urandom});
		immC <= imm_t'({1'($urandom_range(1, 0)), $urandom});
		hold <= initPhase ? 1'b0 : ($urandom_range(7, 0) == 0);
		flush <= initPhase ? 1'b0 : ($urandom_range(7, 0) == 0);
	endtask

	// model follows the DUT at each rising edge, using inputs held over from the last cycle
	task automatic stepEdge();
		@(posedge clock);
		if (!rstN)
			modelReset();
		else if (!hold && !flush)
			modelWrite(writeBack);
	endtask

	task automatic checkOutputs();
		for (int p = 0; p < numReadPorts; p++)
			checkOperand(portName[p], val[p], expectOperand(p, src[p], portImm(p), fwd));
		checkSpecial("regOutDlr", regOutDlr, dlrModel);
		checkSpecial("regOutDhr", regOutDhr, dhrModel);
		checkSpecial("regOutSp", regOutSp, spModel);
	endtask

	initial
	begin
		void'($urandom(runSeed));
		rstN = 1'b0;
		hold = 1'b0;
		flush = 1'b0;
		for (int p = 0; p < numReadPorts; p++)
			src[p] = idZzr;
		immA = '0;
		immB = '0;
		immC = '0;
		fwd = '0;
		for (int l = 0; l < numLanes; l++)
		begin
			writeBack[l].id = idZzr; // no bank writes during reset
			writeBack[l].val = '0;
		end
		for (int c = 0; c < resetCycles; c++)
			stepEdge();
		rstN <= 1'b1;
		for (int c = 0; c < initCycles + randomCycles; c++)
		begin
			driveCycle(c < initCycles, c);
			@(negedge clock); // outputs settled mid-cycle
			checkOutputs();
			stepEdge();
		end
		$display("Test OK");
		$finish;
	end

endmodule
